// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_spc
RTL_TOP   ?= spc_top
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

SIM = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
spc_pkg.sv
spc_cmd_decoder.sv
spc_spi_master.sv
spc_pwm_bank.sv
spc_top.sv
tb_spc.sv

// ==== spc_cmd_decoder.sv ====
`default_nettype none

module spc_cmd_decoder #(
    parameter int NUM_PWM = 8
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [spc_pkg::OPCODE_W-1:0]  cmd_opcode,
    input  wire logic [spc_pkg::ADDR_W-1:0]    cmd_addr,
    input  wire logic [spc_pkg::DATA_W-1:0]    cmd_data,
    input  wire logic                          cmd_valid,
    input  wire logic                          tx_done,
    input  wire logic [spc_pkg::DATA_W-1:0]    spi_rx_word,
    output logic                               spi_start,
    output logic [spc_pkg::DEV_W-1:0]          spi_dev,
    output logic [spc_pkg::DATA_W-1:0]         spi_wdata,
    output logic                               pwm_wr,
    output logic [((NUM_PWM > 1) ? $clog2(NUM_PWM) : 1)-1:0] pwm_sel,
    output logic [spc_pkg::DATA_W-1:0]         pwm_wdata,
    output logic [spc_pkg::DATA_W-1:0]         tx_data,
    output logic                               tx_en
);

    // Channel index width, at least one bit
    localparam int SEL_W = (NUM_PWM > 1) ? $clog2(NUM_PWM) : 1;

    spc_pkg::opcode_e                op;
    logic                            pwm_addr_ok;
    logic                            rd_hit;
    logic [spc_pkg::DATA_W-1:0]      rd_word;

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------

    assign op = spc_pkg::opcode_e'(cmd_opcode);

    // Channel writes outside the bank are dropped here
    assign pwm_addr_ok = int'(cmd_addr) < NUM_PWM;

    // One-cycle strobes straight from the command cycle
    always_comb begin
        spi_start = 1'b0;
        pwm_wr    = 1'b0;
        rd_hit    = 1'b0;
        if (cmd_valid) begin
            case (op)
                spc_pkg::OP_SPI_XFER: spi_start = 1'b1;
                spc_pkg::OP_PWM_CFG:  pwm_wr    = pwm_addr_ok;
                spc_pkg::OP_READ:     rd_hit    = 1'b1;
                default: ;
            endcase
        end
    end

    // Fields to the SPI master
    assign spi_dev   = cmd_addr[spc_pkg::DEV_W-1:0];
    assign spi_wdata = cmd_data;

    // Fields to the PWM bank
    assign pwm_sel   = cmd_addr[SEL_W-1:0];
    assign pwm_wdata = cmd_data;

    // --------------------------------------------------
    // Readback register
    // --------------------------------------------------

    // Only the SPI receive word is mapped
    assign rd_word = (cmd_addr == spc_pkg::RD_ADDR_SPI) ? spi_rx_word : '0;

    // Level flag, held until tx_done in a cycle with no command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_en <= 1'b0;
        end else if (rd_hit) begin
            tx_en <= 1'b1;
        end else if (tx_done && !cmd_valid) begin
            tx_en <= 1'b0;
        end
    end

    // A later read simply overwrites the word
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            tx_data <= rd_word;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // SPI start and PWM write come from different opcodes
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(spi_start && pwm_wr)
    ) else $error("spi_start and pwm_wr high together");

endmodule

`default_nettype wire

// ==== spc_pkg.sv ====
`default_nettype none

package spc_pkg;

    // --------------------------------------------------
    // Command port field widths
    // --------------------------------------------------

    // Opcode, address and data words of one command
    localparam int OPCODE_W = 8;
    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 32;

    // --------------------------------------------------
    // SPI select lines
    // --------------------------------------------------

    // One active-low chip select per attached device
    localparam int CS_W  = 4;
    // Device index comes from the low address bits
    localparam int DEV_W = 2;

    // --------------------------------------------------
    // Readback map
    // --------------------------------------------------

    // Last SPI receive word, every other address reads zero
    localparam logic [ADDR_W-1:0] RD_ADDR_SPI = 'h0001;

    // Supported opcodes
    // Any other encoding is dropped by the decoder
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPI_XFER = 8'h02,
        OP_PWM_CFG  = 8'h07,
        OP_READ     = 8'h08
    } opcode_e;

endpackage

`default_nettype wire

// ==== spc_pwm_bank.sv ====
`default_nettype none

module spc_pwm_bank #(
    parameter int NUM_PWM   = 8,
    parameter int PWM_CNT_W = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          pwm_wr,
    input  wire logic [((NUM_PWM > 1) ? $clog2(NUM_PWM) : 1)-1:0] pwm_sel,
    input  wire logic [spc_pkg::DATA_W-1:0]    pwm_wdata,
    output logic [NUM_PWM-1:0]                 pwm_out
);

    localparam int SEL_W = (NUM_PWM > 1) ? $clog2(NUM_PWM) : 1;
    // Period sits in the upper half of the word
    localparam int PER_LSB = spc_pkg::DATA_W / 2;

    // Both fields must fit into their half of the word
    if (PWM_CNT_W > spc_pkg::DATA_W / 2) begin : g_width_check
        $error("PWM_CNT_W does not fit half of the data word");
    end

    // --------------------------------------------------
    // Channels
    // --------------------------------------------------

    for (genvar i = 0; i < NUM_PWM; i++) begin : g_ch
        logic [PWM_CNT_W-1:0] period_q;
        logic [PWM_CNT_W-1:0] duty_q;
        logic [PWM_CNT_W-1:0] cnt_q;
        logic                 wr_hit;

        assign wr_hit = pwm_wr && (pwm_sel == SEL_W'(i));

        // Config write also restarts the count
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                period_q <= '0;
                duty_q   <= '0;
                cnt_q    <= '0;
            end else if (wr_hit) begin
                period_q <= pwm_wdata[PER_LSB +: PWM_CNT_W];
                duty_q   <= pwm_wdata[0 +: PWM_CNT_W];
                cnt_q    <= '0;
            end else if (period_q == '0 || cnt_q == period_q - 1'b1) begin
                // Zero period parks the counter
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end

        // High for the first duty counts of each period
        assign pwm_out[i] = (period_q != '0) && (cnt_q < duty_q);

        // Zero-period write silences the channel next cycle
        a_zero_period: assert property (
            @(posedge clk) disable iff (!rst_n)
            (wr_hit && pwm_wdata[PER_LSB +: PWM_CNT_W] == '0) |=> !pwm_out[i]
        ) else $error("pwm_out high with zero period");

        // Counter never escapes its period
        a_cnt_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            (period_q != '0) |-> (cnt_q < period_q)
        ) else $error("PWM counter beyond period");
    end

endmodule

`default_nettype wire

// ==== spc_spi_master.sv ====
`default_nettype none

module spc_spi_master (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        spi_start,
    input  wire logic [spc_pkg::DEV_W-1:0]   spi_dev,
    input  wire logic [spc_pkg::DATA_W-1:0]  spi_wdata,
    input  wire logic                        spi_miso,
    output logic                             spi_sclk,
    output logic                             spi_mosi,
    output logic [spc_pkg::CS_W-1:0]         spi_cs,
    output logic [spc_pkg::DATA_W-1:0]       spi_rx_word
);

    // Bit counter wide enough for DATA_W-1
    localparam int CNT_W = $clog2(spc_pkg::DATA_W);

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } spi_state_e;

    spi_state_e                  state;
    logic [CNT_W-1:0]            bit_cnt;
    logic [spc_pkg::DATA_W-1:0]  shift_reg;
    logic [spc_pkg::CS_W-1:0]    cs_sel;
    logic [spc_pkg::DATA_W-1:0]  shift_next;
    logic                        last_bit;

    // --------------------------------------------------
    // Chip select decode and shift helpers
    // --------------------------------------------------

    // One-hot of the addressed device
    assign cs_sel = {{(spc_pkg::CS_W-1){1'b0}}, 1'b1} << spi_dev;

    // Shift left, new MISO sample enters at the LSB
    assign shift_next = {shift_reg[spc_pkg::DATA_W-2:0], spi_miso};

    assign last_bit = (bit_cnt == '0);

    // --------------------------------------------------
    // Shift engine
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            spi_sclk  <= 1'b0;
            spi_mosi  <= 1'b0;
            spi_cs    <= '1;
            bit_cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    spi_sclk <= 1'b0;
                    // Select the device, data loads in the payload block
                    if (spi_start) begin
                        state   <= ST_SHIFT;
                        spi_cs  <= ~cs_sel;
                        bit_cnt <= CNT_W'(spc_pkg::DATA_W - 1);
                    end
                end
                ST_SHIFT: begin
                    // Divide by two, one toggle per clock
                    spi_sclk <= ~spi_sclk;
                    if (spi_sclk) begin
                        // Falling SCLK, present next bit MSB first
                        spi_mosi <= shift_reg[spc_pkg::DATA_W-1];
                        if (last_bit) begin
                            state  <= ST_IDLE;
                            spi_cs <= '1;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    spi_sclk <= 1'b0;
                    spi_cs   <= '1;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Shift and capture registers
    // --------------------------------------------------

    // Start is ignored while a transfer is running
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && spi_start) begin
            shift_reg <= spi_wdata;
        end else if (state == ST_SHIFT && spi_sclk) begin
            shift_reg <= shift_next;
        end
    end

    // Held until the next transfer completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spi_rx_word <= '0;
        end else if (state == ST_SHIFT && spi_sclk && last_bit) begin
            spi_rx_word <= shift_next;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Never more than one device selected
    a_cs_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $countones(~spi_cs) <= 1
    ) else $error("spi_cs selects more than one device");

    // No clock edges outside a transfer
    a_sclk_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (&spi_cs) |-> !spi_sclk
    ) else $error("spi_sclk high with no chip select");

endmodule

`default_nettype wire

// ==== spc_top.sv ====
`default_nettype none

module spc_top #(
    parameter int NUM_PWM   = 8,
    parameter int PWM_CNT_W = 16
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // Command port
    input  wire logic [spc_pkg::OPCODE_W-1:0]  cmd_opcode,
    input  wire logic [spc_pkg::ADDR_W-1:0]    cmd_addr,
    input  wire logic [spc_pkg::DATA_W-1:0]    cmd_data,
    input  wire logic                          cmd_valid,

    // SPI pins
    output logic                               spi_sclk,
    output logic                               spi_mosi,
    input  wire logic                          spi_miso,
    output logic [spc_pkg::CS_W-1:0]           spi_cs,

    // PWM pins
    output logic [NUM_PWM-1:0]                 pwm_out,

    // Readback
    output logic [spc_pkg::DATA_W-1:0]         tx_data,
    output logic                               tx_en,
    input  wire logic                          tx_done
);

    localparam int SEL_W = (NUM_PWM > 1) ? $clog2(NUM_PWM) : 1;

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------

    // Decoder to SPI master
    logic                        spi_start;
    logic [spc_pkg::DEV_W-1:0]   spi_dev;
    logic [spc_pkg::DATA_W-1:0]  spi_wdata;
    // SPI master back to decoder
    logic [spc_pkg::DATA_W-1:0]  spi_rx_word;
    // Decoder to PWM bank
    logic                        pwm_wr;
    logic [SEL_W-1:0]            pwm_sel;
    logic [spc_pkg::DATA_W-1:0]  pwm_wdata;

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------

    spc_cmd_decoder #(
        .NUM_PWM (NUM_PWM)
    ) i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_opcode  (cmd_opcode),
        .cmd_addr    (cmd_addr),
        .cmd_data    (cmd_data),
        .cmd_valid   (cmd_valid),
        .tx_done     (tx_done),
        .spi_rx_word (spi_rx_word),
        .spi_start   (spi_start),
        .spi_dev     (spi_dev),
        .spi_wdata   (spi_wdata),
        .pwm_wr      (pwm_wr),
        .pwm_sel     (pwm_sel),
        .pwm_wdata   (pwm_wdata),
        .tx_data     (tx_data),
        .tx_en       (tx_en)
    );

    spc_spi_master i_spi (
        .clk         (clk),
        .rst_n       (rst_n),
        .spi_start   (spi_start),
        .spi_dev     (spi_dev),
        .spi_wdata   (spi_wdata),
        .spi_miso    (spi_miso),
        .spi_sclk    (spi_sclk),
        .spi_mosi    (spi_mosi),
        .spi_cs      (spi_cs),
        .spi_rx_word (spi_rx_word)
    );

    // PWM outputs go straight to the pins
    spc_pwm_bank #(
        .NUM_PWM   (NUM_PWM),
        .PWM_CNT_W (PWM_CNT_W)
    ) i_pwm (
        .clk       (clk),
        .rst_n     (rst_n),
        .pwm_wr    (pwm_wr),
        .pwm_sel   (pwm_sel),
        .pwm_wdata (pwm_wdata),
        .pwm_out   (pwm_out)
    );

endmodule

`default_nettype wire

// ==== tb_spc.sv ====
`default_nettype none

module tb_spc;

    // Reset 16, bad commands ~15, 8 transfers ~75 each, 9 PWM windows ~40 each
    localparam int MAX_CYCLES = 3000;

    logic                          clk;
    logic                          rst_n;
    logic [spc_pkg::OPCODE_W-1:0]  cmd_opcode;
    logic [spc_pkg::ADDR_W-1:0]    cmd_addr;
    logic [spc_pkg::DATA_W-1:0]    cmd_data;
    logic                          cmd_valid;
    logic                          spi_miso;
    logic                          tx_done;
    logic                          spi_sclk;
    logic                          spi_mosi;
    logic [spc_pkg::CS_W-1:0]      spi_cs;
    logic [7:0]                    pwm_out;
    logic [spc_pkg::DATA_W-1:0]    tx_data;
    logic                          tx_en;

    logic [31:0]                   lfsr;
    int unsigned                   cycle_cnt;
    // Expected values, changed only between checks
    logic [spc_pkg::CS_W-1:0]      exp_cs;
    logic [31:0]                   exp_rd;
    logic                          quiet;
    // SPI slave state
    logic [31:0]                   miso_word;
    int                            miso_idx;
    logic [31:0]                   mosi_bits;
    int                            mosi_cnt;

    spc_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_opcode (cmd_opcode),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_valid  (cmd_valid),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .spi_cs     (spi_cs),
        .pwm_out    (pwm_out),
        .tx_data    (tx_data),
        .tx_en      (tx_en),
        .tx_done    (tx_done)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic string mismatch_line(input string name, input logic [31:0] got,
                                            input logic [31:0] exp);
        return $sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    endfunction

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    // --------------------------------------------------
    // SPI slave model
    // --------------------------------------------------

    // Pattern goes out MSB first on rising SCLK
    always @(posedge spi_sclk) begin
        #10;
        if (miso_idx < 32) begin
            spi_miso = miso_word[31 - miso_idx];
            miso_idx = miso_idx + 1;
        end
    end

    // MOSI is settled shortly after falling SCLK
    always @(negedge spi_sclk) begin
        #5;
        mosi_bits = {mosi_bits[30:0], spi_mosi};
        mosi_cnt  = mosi_cnt + 1;
    end

    // --------------------------------------------------
    // Concurrent checks
    // --------------------------------------------------

    // Ignored commands leave every output alone
    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> (spi_cs == '1 && !tx_en && pwm_out == '0)
    ) else fail_run($sformatf(
        "** Error: after bad command spi_cs = 0x%0h tx_en = 0x%0h pwm_out = 0x%0h",
        spi_cs, tx_en, pwm_out));

    a_cs_select: assert property (@(posedge clk) disable iff (!rst_n)
        (spi_cs != '1) |-> (spi_cs == exp_cs)
    ) else fail_run(mismatch_line("spi_cs", 32'(spi_cs), 32'(exp_cs)));

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && cmd_opcode == spc_pkg::OP_READ) |=> (tx_en && tx_data == exp_rd)
    ) else fail_run(mismatch_line("tx_data", tx_data, exp_rd));

    a_tx_release: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_en && tx_done && !cmd_valid) |=> !tx_en
    ) else fail_run(mismatch_line("tx_en", 32'(tx_en), 32'h0));

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    // Called and returns 10 units after a rising edge
    task automatic send_cmd(input logic [7:0] op, input logic [15:0] addr,
                            input logic [31:0] data);
        cmd_opcode = op;
        cmd_addr   = addr;
        cmd_data   = data;
        cmd_valid  = 1'b1;
        @(posedge clk);
        #10;
        cmd_valid  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic release_readback();
        tx_done = 1'b1;
        idle_cycles(1);
        tx_done = 1'b0;
        idle_cycles(1);
        assert (!tx_en) else fail_run(mismatch_line("tx_en", 32'(tx_en), 32'h0));
    endtask

    // PWM writes past the bank and unknown opcodes
    task automatic run_bad_cmds();
        logic [7:0] op;
        for (int i = 0; i < 4; i++) begin
            send_cmd(spc_pkg::OP_PWM_CFG, 16'd8 + 16'(take_bits(8)), 32'h0004_0002);
            op = 8'(take_bits(8));
            if (op == spc_pkg::OP_SPI_XFER || op == spc_pkg::OP_PWM_CFG ||
                op == spc_pkg::OP_READ) begin
                op = 8'hff;
            end
            send_cmd(op, 16'(take_bits(3)), take_bits(32));
        end
    endtask

    task automatic run_spi_xfer();
        logic [31:0] word;
        logic [1:0]  dev;
        logic [15:0] addr;
        word      = take_bits(32);
        dev       = 2'(take_bits(2));
        miso_word = take_bits(32);
        miso_idx  = 0;
        mosi_cnt  = 0;
        mosi_bits = '0;
        exp_cs    = '1;
        exp_cs[dev] = 1'b0;
        send_cmd(spc_pkg::OP_SPI_XFER, {14'(take_bits(14)), dev}, word);
        assert (spi_cs == exp_cs) else fail_run(mismatch_line("spi_cs", 32'(spi_cs), 32'(exp_cs)));
        do begin
            idle_cycles(1);
        end while (spi_cs != '1);
        assert (mosi_cnt == 32) else fail_run(mismatch_line("mosi bit count", mosi_cnt, 32));
        assert (mosi_bits == word) else fail_run(mismatch_line("spi_mosi", mosi_bits, word));
        // Readback of the slave pattern, then of an unmapped address
        exp_rd = miso_word;
        send_cmd(spc_pkg::OP_READ, spc_pkg::RD_ADDR_SPI, take_bits(32));
        assert (tx_en && tx_data == exp_rd)
            else fail_run(mismatch_line("tx_data", tx_data, exp_rd));
        release_readback();
        addr = 16'(take_bits(16));
        if (addr == spc_pkg::RD_ADDR_SPI) begin
            addr = 16'h0002;
        end
        exp_rd = '0;
        send_cmd(spc_pkg::OP_READ, addr, take_bits(32));
        release_readback();
    endtask

    // High count over one full period is min(duty, period)
    task automatic run_pwm_channel(input int ch, input logic [15:0] period,
                                   input logic [15:0] duty);
        int high_cnt;
        int exp_high;
        int window;
        send_cmd(spc_pkg::OP_PWM_CFG, 16'(ch), {period, duty});
        idle_cycles(int'(take_bits(3)));
        window   = (period == '0) ? 24 : int'(period);
        exp_high = (period == '0) ? 0 : ((duty < period) ? int'(duty) : int'(period));
        high_cnt = 0;
        for (int i = 0; i < window; i++) begin
            if (pwm_out[ch]) begin
                high_cnt++;
            end
            idle_cycles(1);
        end
        assert (high_cnt == exp_high) else fail_run(mismatch_line("pwm_out high cycles",
                                                                  high_cnt, exp_high));
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_opcode = '0;
        cmd_addr   = '0;
        cmd_data   = '0;
        cmd_valid  = 1'b0;
        spi_miso   = 1'b0;
        tx_done    = 1'b0;
        lfsr       = 32'd78025;
        cycle_cnt  = 0;
        exp_cs     = '1;
        exp_rd     = '0;
        quiet      = 1'b0;
        miso_word  = '0;
        miso_idx   = 32;
        mosi_bits  = '0;
        mosi_cnt   = 0;
        repeat (16) @(posedge clk);
        #10;
        // Reset values on every output pin
        assert (spi_cs == '1 && !spi_sclk && !spi_mosi && !tx_en && pwm_out == '0)
            else fail_run($sformatf(
                "** Error: in reset spi_cs = 0x%0h tx_en = 0x%0h pwm_out = 0x%0h",
                spi_cs, tx_en, pwm_out));
        rst_n = 1'b1;

        quiet = 1'b1;
        run_bad_cmds();
        idle_cycles(4);
        quiet = 1'b0;

        repeat (8) run_spi_xfer();

        for (int ch = 0; ch < 8; ch++) begin
            run_pwm_channel(ch, 16'd1 + 16'(take_bits(5)), 16'(take_bits(6)));
        end
        // A running channel parked by a zero period
        run_pwm_channel(int'(take_bits(3)), 16'd0, 16'd1 + 16'(take_bits(4)));

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
